//--- logic/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // rv32i major opcodes
    localparam logic [6:0] OP_R_TYPE   = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE   = 7'b0010011;
    localparam logic [6:0] OP_I_TYPE_L = 7'b0000011; // loads
    localparam logic [6:0] OP_S_TYPE   = 7'b0100011; // stores
    localparam logic [6:0] OP_B_TYPE   = 7'b1100011; // branches
    localparam logic [6:0] OP_J_TYPE   = 7'b1101111; // jal
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_AUIPC    = 7'b0010111;
    localparam logic [6:0] OP_LUI      = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_OP_NONE = 4'd0,
        ALU_OP_ADD  = 4'd1,
        ALU_OP_SUB  = 4'd2,
        ALU_OP_AND  = 4'd3,
        ALU_OP_OR   = 4'd4,
        ALU_OP_XOR  = 4'd5,
        ALU_OP_SLL  = 4'd6,
        ALU_OP_SRL  = 4'd7,
        ALU_OP_SRA  = 4'd8,
        ALU_OP_SLT  = 4'd9,
        ALU_OP_SLTU = 4'd10
    } alu_op_e;

    typedef enum logic [3:0] {
        PC_SRC_NONE         = 4'd0, // no valid target, flagged illegal
        PC_SRC_PLUS_4       = 4'd1,
        PC_SRC_PLUS_OFF     = 4'd2,
        PC_SRC_REG_PLUS_OFF = 4'd3
    } pc_src_e;

    typedef struct packed {
        logic neg;  // bit 31 of a - b
        logic zero; // alu result is zero
        logic cout; // set when a >= b unsigned
        logic ov;   // signed overflow of a - b
    } alu_flags_t;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [2:0]  func3;
        logic [4:0]  rd;
        alu_op_e     alu_ctrl;
        logic [31:0] operand_a;
        logic [31:0] operand_b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic        mem_op;
        logic        illegal;
    } dec_pkt_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] rd_data;
        logic [31:0] next_pc;
        logic        mem_op;
        logic        illegal;
    } exec_rsp_t;

endpackage

`default_nettype wire

//--- logic/rv_ctrl_dec.sv
`default_nettype none

module alu_dec (
    input  wire  [6:0]          op,
    input  wire  [2:0]          func3,
    input  wire  [6:0]          func7,
    output rv_exec_pkg::alu_op_e alu_ctrl
);
    rv_exec_pkg::alu_op_e ri_type_alu_ctrl;

    // shared decode for register and immediate arithmetic
    always_comb begin
        case (func3)
            3'b000: begin
                if (op == rv_exec_pkg::OP_R_TYPE && func7[5]) begin
                    ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_SUB; // addi has no sub form
                end else begin
                    ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_ADD;
                end
            end
            3'b001:  ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_SLL;
            3'b010:  ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_SLT;
            3'b011:  ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_SLTU;
            3'b100:  ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_XOR;
            3'b101: begin
                // srai carries the same func7 bit as sra
                ri_type_alu_ctrl = func7[5] ? rv_exec_pkg::ALU_OP_SRA
                                            : rv_exec_pkg::ALU_OP_SRL;
            end
            3'b110:  ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_OR;
            default: ri_type_alu_ctrl = rv_exec_pkg::ALU_OP_AND; // 3'b111
        endcase
    end

    always_comb begin
        case (op)
            rv_exec_pkg::OP_R_TYPE:   alu_ctrl = ri_type_alu_ctrl;
            rv_exec_pkg::OP_I_TYPE:   alu_ctrl = ri_type_alu_ctrl;
            rv_exec_pkg::OP_I_TYPE_L: alu_ctrl = rv_exec_pkg::ALU_OP_ADD; // address calc
            rv_exec_pkg::OP_S_TYPE:   alu_ctrl = rv_exec_pkg::ALU_OP_ADD;
            rv_exec_pkg::OP_B_TYPE:   alu_ctrl = rv_exec_pkg::ALU_OP_SUB; // compare via flags
            rv_exec_pkg::OP_AUIPC:    alu_ctrl = rv_exec_pkg::ALU_OP_ADD;
            rv_exec_pkg::OP_J_TYPE:   alu_ctrl = rv_exec_pkg::ALU_OP_ADD;
            rv_exec_pkg::OP_JALR:     alu_ctrl = rv_exec_pkg::ALU_OP_ADD;
            default:                  alu_ctrl = rv_exec_pkg::ALU_OP_NONE; // lui too
        endcase
    end
endmodule

module branch_pc_src_dec (
    input  wire  [6:0]             op,
    input  wire  [2:0]             func3,
    input  wire  rv_exec_pkg::alu_flags_t alu_flags,
    output rv_exec_pkg::pc_src_e    pc_src
);
    rv_exec_pkg::pc_src_e pc_src_b_type;
    logic                 lt_signed;

    assign lt_signed = alu_flags.neg ^ alu_flags.ov;

    always_comb begin
        case (func3)
            3'b000:  pc_src_b_type = alu_flags.zero ? rv_exec_pkg::PC_SRC_PLUS_OFF
                                                    : rv_exec_pkg::PC_SRC_PLUS_4;   // beq
            3'b001:  pc_src_b_type = alu_flags.zero ? rv_exec_pkg::PC_SRC_PLUS_4
                                                    : rv_exec_pkg::PC_SRC_PLUS_OFF; // bne
            3'b100:  pc_src_b_type = lt_signed ? rv_exec_pkg::PC_SRC_PLUS_OFF
                                               : rv_exec_pkg::PC_SRC_PLUS_4;        // blt
            3'b101:  pc_src_b_type = lt_signed ? rv_exec_pkg::PC_SRC_PLUS_4
                                               : rv_exec_pkg::PC_SRC_PLUS_OFF;      // bge
            3'b110:  pc_src_b_type = alu_flags.cout ? rv_exec_pkg::PC_SRC_PLUS_4
                                                    : rv_exec_pkg::PC_SRC_PLUS_OFF; // bltu
            3'b111:  pc_src_b_type = alu_flags.cout ? rv_exec_pkg::PC_SRC_PLUS_OFF
                                                    : rv_exec_pkg::PC_SRC_PLUS_4;   // bgeu
            default: pc_src_b_type = rv_exec_pkg::PC_SRC_NONE;
        endcase
    end

    always_comb begin
        case (op)
            rv_exec_pkg::OP_B_TYPE:   pc_src = pc_src_b_type;
            rv_exec_pkg::OP_J_TYPE:   pc_src = rv_exec_pkg::PC_SRC_PLUS_OFF;
            rv_exec_pkg::OP_JALR:     pc_src = rv_exec_pkg::PC_SRC_REG_PLUS_OFF;
            rv_exec_pkg::OP_AUIPC,
            rv_exec_pkg::OP_LUI,
            rv_exec_pkg::OP_I_TYPE_L,
            rv_exec_pkg::OP_I_TYPE,
            rv_exec_pkg::OP_S_TYPE,
            rv_exec_pkg::OP_R_TYPE:   pc_src = rv_exec_pkg::PC_SRC_PLUS_4;
            7'b0000000:               pc_src = rv_exec_pkg::PC_SRC_PLUS_4; // zero word nop
            default:                  pc_src = rv_exec_pkg::PC_SRC_NONE;
        endcase
    end

    // every legal opcode and branch condition must map to a real target
    always_comb begin
        if (!$isunknown({op, func3, alu_flags}) &&
            op inside {rv_exec_pkg::OP_R_TYPE, rv_exec_pkg::OP_I_TYPE,
                       rv_exec_pkg::OP_I_TYPE_L, rv_exec_pkg::OP_S_TYPE,
                       rv_exec_pkg::OP_B_TYPE, rv_exec_pkg::OP_J_TYPE,
                       rv_exec_pkg::OP_JALR, rv_exec_pkg::OP_AUIPC,
                       rv_exec_pkg::OP_LUI} &&
            !(op == rv_exec_pkg::OP_B_TYPE && func3[2:1] == 2'b01)) begin
            assert final (pc_src != rv_exec_pkg::PC_SRC_NONE)
                else $error("pc source none for legal opcode %b", op);
        end
    end
endmodule

`default_nettype wire

//--- logic/instr_decode.sv
`default_nettype none

module instr_decode (
    input  wire  rv_exec_pkg::exec_req_t req,
    output rv_exec_pkg::dec_pkt_t        pkt
);
    logic [31:0]          instr;
    logic [6:0]           op;
    logic [6:0]           func7;
    logic [31:0]          imm;
    logic                 known_op;
    rv_exec_pkg::alu_op_e alu_ctrl;

    assign instr = req.instr;
    assign op    = instr[6:0];
    assign func7 = instr[31:25];

    alu_dec u_alu_dec (
        .op       (op),
        .func3    (instr[14:12]),
        .func7    (func7),
        .alu_ctrl (alu_ctrl)
    );

    // immediate format chosen by opcode
    always_comb begin
        case (op)
            rv_exec_pkg::OP_I_TYPE,
            rv_exec_pkg::OP_I_TYPE_L,
            rv_exec_pkg::OP_JALR:  imm = {{20{instr[31]}}, instr[31:20]};
            rv_exec_pkg::OP_S_TYPE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_exec_pkg::OP_B_TYPE: imm = {{19{instr[31]}}, instr[31], instr[7],
                                           instr[30:25], instr[11:8], 1'b0};
            rv_exec_pkg::OP_LUI,
            rv_exec_pkg::OP_AUIPC: imm = {instr[31:12], 12'b0};
            rv_exec_pkg::OP_J_TYPE: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                           instr[20], instr[30:21], 1'b0};
            default:               imm = 32'b0;
        endcase
    end

    assign known_op = op inside {rv_exec_pkg::OP_R_TYPE, rv_exec_pkg::OP_I_TYPE,
                                 rv_exec_pkg::OP_I_TYPE_L, rv_exec_pkg::OP_S_TYPE,
                                 rv_exec_pkg::OP_B_TYPE, rv_exec_pkg::OP_J_TYPE,
                                 rv_exec_pkg::OP_JALR, rv_exec_pkg::OP_AUIPC,
                                 rv_exec_pkg::OP_LUI};

    always_comb begin
        pkt.op        = op;
        pkt.func3     = instr[14:12];
        pkt.rd        = instr[11:7];
        pkt.alu_ctrl  = alu_ctrl;
        pkt.operand_a = req.rs1_val;
        // register compare for branches, immediate for everything else
        pkt.operand_b = (op == rv_exec_pkg::OP_R_TYPE || op == rv_exec_pkg::OP_B_TYPE)
                        ? req.rs2_val : imm;
        pkt.imm       = imm;
        pkt.pc        = req.pc;
        pkt.rs1_val   = req.rs1_val;
        pkt.mem_op    = (op == rv_exec_pkg::OP_I_TYPE_L) || (op == rv_exec_pkg::OP_S_TYPE);
        pkt.illegal   = !known_op && (instr != 32'b0); // all-zero word passes as nop
    end
endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
    input  wire  rv_exec_pkg::alu_op_e ctrl,
    input  wire  [31:0]                a,
    input  wire  [31:0]                b,
    output logic [31:0]                result,
    output rv_exec_pkg::alu_flags_t    flags
);
    logic [32:0] diff;
    logic [4:0]  shamt;

    assign diff  = {1'b0, a} + {1'b0, ~b} + 33'd1; // a - b with carry out
    assign shamt = b[4:0];

    always_comb begin
        case (ctrl)
            rv_exec_pkg::ALU_OP_ADD:  result = a + b;
            rv_exec_pkg::ALU_OP_SUB:  result = diff[31:0];
            rv_exec_pkg::ALU_OP_AND:  result = a & b;
            rv_exec_pkg::ALU_OP_OR:   result = a | b;
            rv_exec_pkg::ALU_OP_XOR:  result = a ^ b;
            rv_exec_pkg::ALU_OP_SLL:  result = a << shamt;
            rv_exec_pkg::ALU_OP_SRL:  result = a >> shamt;
            rv_exec_pkg::ALU_OP_SRA:  result = $signed(a) >>> shamt;
            rv_exec_pkg::ALU_OP_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_exec_pkg::ALU_OP_SLTU: result = {31'b0, a < b};
            default:                  result = 32'b0;
        endcase
    end

    // flags always reflect the subtraction so branches can use them
    assign flags.neg  = diff[31];
    assign flags.zero = (result == 32'b0);
    assign flags.cout = diff[32];
    assign flags.ov   = (a[31] != b[31]) && (diff[31] != a[31]);

    // beq/bne rely on zero meaning a == b under sub
    always_comb begin
        if (!$isunknown({ctrl, a, b}) && ctrl == rv_exec_pkg::ALU_OP_SUB) begin
            assert final (flags.zero == (a == b))
                else $error("zero flag disagrees with a == b under sub");
        end
    end
endmodule

`default_nettype wire

//--- logic/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           in_valid,
    output logic          in_ready,
    input  wire PAYLOAD_T in_data,
    output logic          out_valid,
    input  wire           out_ready,
    output PAYLOAD_T      out_data
);
    assign in_ready = out_ready || !out_valid; // free slot or draining this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // held output must not change while downstream stalls
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("pipe stage output changed under stall");
endmodule

`default_nettype wire

//--- logic/exec_result.sv
`default_nettype none

module exec_result (
    input  wire  rv_exec_pkg::dec_pkt_t     pkt,
    input  wire  [31:0]                     alu_result,
    input  wire  rv_exec_pkg::alu_flags_t   alu_flags,
    output rv_exec_pkg::exec_rsp_t          rsp
);
    rv_exec_pkg::pc_src_e pc_src;
    logic [31:0]          pc_plus_4;
    logic [31:0]          jalr_target;
    logic                 writes_rd;

    branch_pc_src_dec u_pc_src_dec (
        .op        (pkt.op),
        .func3     (pkt.func3),
        .alu_flags (alu_flags),
        .pc_src    (pc_src)
    );

    assign pc_plus_4   = pkt.pc + 32'd4;
    assign jalr_target = pkt.rs1_val + pkt.imm;

    always_comb begin
        case (pc_src)
            rv_exec_pkg::PC_SRC_PLUS_OFF:     rsp.next_pc = pkt.pc + pkt.imm;
            rv_exec_pkg::PC_SRC_REG_PLUS_OFF: rsp.next_pc = {jalr_target[31:1], 1'b0};
            default:                          rsp.next_pc = pc_plus_4; // none falls through
        endcase
    end

    always_comb begin
        case (pkt.op)
            rv_exec_pkg::OP_LUI:      rsp.rd_data = pkt.imm;
            rv_exec_pkg::OP_AUIPC:    rsp.rd_data = pkt.pc + pkt.imm;
            rv_exec_pkg::OP_J_TYPE,
            rv_exec_pkg::OP_JALR:     rsp.rd_data = pc_plus_4; // link address
            rv_exec_pkg::OP_I_TYPE_L,
            rv_exec_pkg::OP_S_TYPE,
            rv_exec_pkg::OP_R_TYPE,
            rv_exec_pkg::OP_I_TYPE:   rsp.rd_data = alu_result; // add gives the address
            default:                  rsp.rd_data = 32'b0;
        endcase
    end

    assign writes_rd = pkt.op inside {rv_exec_pkg::OP_R_TYPE, rv_exec_pkg::OP_I_TYPE,
                                      rv_exec_pkg::OP_I_TYPE_L, rv_exec_pkg::OP_LUI,
                                      rv_exec_pkg::OP_AUIPC, rv_exec_pkg::OP_J_TYPE,
                                      rv_exec_pkg::OP_JALR};

    assign rsp.illegal = pkt.illegal || (pc_src == rv_exec_pkg::PC_SRC_NONE);
    assign rsp.rd_we   = writes_rd && (pkt.rd != 5'd0) && !rsp.illegal;
    assign rsp.rd      = pkt.rd;
    assign rsp.mem_op  = pkt.mem_op;
endmodule

`default_nettype wire

//--- logic/rv_exec_unit.sv
`default_nettype none

module rv_exec_unit (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          in_valid,
    output logic                         in_ready,
    input  wire  rv_exec_pkg::exec_req_t in_req,
    output logic                         out_valid,
    input  wire                          out_ready,
    output rv_exec_pkg::exec_rsp_t       out_rsp
);
    rv_exec_pkg::dec_pkt_t   dec_pkt;
    rv_exec_pkg::dec_pkt_t   dec_pkt_q;
    logic                    dec_valid;
    logic                    dec_ready;    // rsp stage has room
    logic [31:0]             alu_result;
    rv_exec_pkg::alu_flags_t alu_flags;
    rv_exec_pkg::exec_rsp_t  rsp;

    instr_decode u_decode (
        .req (in_req),
        .pkt (dec_pkt)
    );

    pipe_stage #(.PAYLOAD_T(rv_exec_pkg::dec_pkt_t)) u_dec_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_pkt),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_pkt_q)
    );

    alu u_alu (
        .ctrl   (dec_pkt_q.alu_ctrl),
        .a      (dec_pkt_q.operand_a),
        .b      (dec_pkt_q.operand_b),
        .result (alu_result),
        .flags  (alu_flags)
    );

    exec_result u_result (
        .pkt        (dec_pkt_q),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .rsp        (rsp)
    );

    pipe_stage #(.PAYLOAD_T(rv_exec_pkg::exec_rsp_t)) u_rsp_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_rsp)
    );
endmodule

`default_nettype wire

//--- verification/rv_exec_tb.sv
`default_nettype none

module rv_exec_tb;

    localparam int NUM_INSTR      = 121;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 200;
    // r-type func3, lsb first: add sub and or xor sll srl sra slt sltu
    localparam logic [29:0] R_F3 = {3'd3, 3'd2, 3'd5, 3'd5, 3'd1, 3'd4, 3'd6, 3'd7, 3'd0, 3'd0};
    localparam logic [9:0]  R_F7 = 10'b0010000010; // sub and sra

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    rv_exec_pkg::exec_req_t in_req;
    logic                   out_valid;
    logic                   out_ready;
    rv_exec_pkg::exec_rsp_t out_rsp;

    rv_exec_pkg::exec_rsp_t exp_q[$]; // expected responses in issue order
    rv_exec_pkg::exec_rsp_t exp_rsp;
    integer                 seed = 32'hf43d;
    integer                 ready_seed = 32'hf43d; // separate stream for out_ready
    logic [31:0]            ready_rnd;
    logic [31:0]            cur_pc;
    logic                   stall_mode;
    int                     value_errors = 0;
    int                     other_errors = 0;
    int                     accepted = 0;
    int                     delivered = 0;
    int                     cycles = 0;

    rv_exec_unit i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d responses missing", cycles, exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (stall_mode) begin
            ready_rnd = $random(ready_seed);
            out_ready <= ready_rnd[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic f7b5,
                                          input logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, 5'd2, 5'd1, f3, rd, rv_exec_pkg::OP_R_TYPE};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], rv_exec_pkg::OP_S_TYPE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], rv_exec_pkg::OP_B_TYPE};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::OP_J_TYPE};
    endfunction

    function automatic logic [31:0] edge_val(input int k);
        case (k)
            0:       return 32'h0;
            1:       return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // integer arithmetic straight from the rv32i spec
    function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic sub,
                                              input logic arith, input logic [31:0] a,
                                              input logic [31:0] b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (arith) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic rv_exec_pkg::exec_rsp_t expected_rsp(input rv_exec_pkg::exec_req_t r);
        rv_exec_pkg::exec_rsp_t e;
        logic [31:0]            ins;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            pc4;
        logic [31:0]            i_imm;
        logic [31:0]            s_imm;
        logic [31:0]            b_imm;
        logic [31:0]            u_imm;
        logic [31:0]            j_imm;
        logic                   is_r;
        logic                   writes;
        logic                   taken;
        ins   = r.instr;
        a     = r.rs1_val;
        pc4   = r.pc + 32'd4;
        i_imm = {{20{ins[31]}}, ins[31:20]};
        s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        u_imm = {ins[31:12], 12'b0};
        j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        is_r  = (ins[6:0] == rv_exec_pkg::OP_R_TYPE);
        e         = '0;
        e.rd      = ins[11:7];
        e.next_pc = pc4;
        writes    = 1'b0;
        taken     = 1'b0;
        case (ins[6:0])
            rv_exec_pkg::OP_R_TYPE, rv_exec_pkg::OP_I_TYPE: begin
                b = is_r ? r.rs2_val : i_imm;
                e.rd_data = arith_ref(ins[14:12], is_r && ins[30], ins[30], a, b);
                writes = 1'b1;
            end
            rv_exec_pkg::OP_I_TYPE_L: begin
                e.rd_data = a + i_imm;
                e.mem_op  = 1'b1;
                writes    = 1'b1;
            end
            rv_exec_pkg::OP_S_TYPE: begin
                e.rd_data = a + s_imm;
                e.mem_op  = 1'b1;
            end
            rv_exec_pkg::OP_B_TYPE: begin
                case (ins[14:12])
                    3'd0:    taken = (a == r.rs2_val);
                    3'd1:    taken = (a != r.rs2_val);
                    3'd4:    taken = ($signed(a) < $signed(r.rs2_val));
                    3'd5:    taken = ($signed(a) >= $signed(r.rs2_val));
                    3'd6:    taken = (a < r.rs2_val);
                    3'd7:    taken = (a >= r.rs2_val);
                    default: e.illegal = 1'b1;
                endcase
                if (taken) begin
                    e.next_pc = r.pc + b_imm;
                end
            end
            rv_exec_pkg::OP_J_TYPE: begin
                e.rd_data = pc4;
                e.next_pc = r.pc + j_imm;
                writes    = 1'b1;
            end
            rv_exec_pkg::OP_JALR: begin
                e.rd_data = pc4;
                e.next_pc = (a + i_imm) & 32'hffff_fffe;
                writes    = 1'b1;
            end
            rv_exec_pkg::OP_LUI: begin
                e.rd_data = u_imm;
                writes    = 1'b1;
            end
            rv_exec_pkg::OP_AUIPC: begin
                e.rd_data = r.pc + u_imm;
                writes    = 1'b1;
            end
            default: e.illegal = (ins != 32'h0); // zero word is a nop
        endcase
        e.rd_we = writes && (e.rd != 5'd0) && !e.illegal;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("[ERROR] %s = 0x%0h, expected 0x%0h (response %0d)", name, got, want,
                     delivered);
        end
    endtask

    task automatic compare_rsp(input rv_exec_pkg::exec_rsp_t got,
                               input rv_exec_pkg::exec_rsp_t want);
        check_val("out_rsp.rd", got.rd, want.rd);
        check_val("out_rsp.rd_we", got.rd_we, want.rd_we);
        check_val("out_rsp.rd_data", got.rd_data, want.rd_data);
        check_val("out_rsp.next_pc", got.next_pc, want.next_pc);
        check_val("out_rsp.mem_op", got.mem_op, want.mem_op);
        check_val("out_rsp.illegal", got.illegal, want.illegal);
    endtask

    // in-order scoreboard on output transfers
    always @(posedge clk) begin
        if (!reset) begin
            if (accepted - delivered == 2 && !out_ready && in_ready) begin
                other_errors++;
                $display("in_ready was high while both stages held an instruction");
            end
            if (in_valid && in_ready) begin
                accepted++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("output transfer arrived with no instruction outstanding");
                end else begin
                    exp_rsp = exp_q.pop_front();
                    compare_rsp(out_rsp, exp_rsp);
                end
                delivered++;
            end
        end
    end

    // hold the request until the unit takes it
    task automatic issue(input logic [31:0] instr, input logic [31:0] rs1,
                         input logic [31:0] rs2);
        rv_exec_pkg::exec_req_t req;
        req.instr   = instr;
        req.pc      = cur_pc;
        req.rs1_val = rs1;
        req.rs2_val = rs2;
        exp_q.push_back(expected_rsp(req));
        cur_pc = cur_pc + 32'd4;
        in_valid <= 1'b1;
        in_req   <= req;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic check_reset_state();
        check_val("out_valid", out_valid, 32'd0);
        check_val("in_ready", in_ready, 32'd1);
    endtask

    task automatic run_r_type();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 4; k++) begin
                if (k < 3) begin
                    a = edge_val(k);
                    b = edge_val((k + 1) % 3);
                end else begin
                    a = $random(seed);
                    b = $random(seed);
                end
                rd = 5'd1 + 5'((i * 4 + k) % 31);
                issue(enc_r(R_F3[3*i +: 3], R_F7[i], rd), a, b);
            end
        end
        issue(enc_r(3'd0, 1'b0, 5'd0), 32'h1234, 32'h4321); // add to x0
    endtask

    task automatic run_i_type_mem();
        issue(enc_i(12'hfff, 3'd0, 5'd3, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h800, 3'd0, 5'd3, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h7ff, 3'd0, 5'd3, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'hffe, 3'd2, 5'd4, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'hffe, 3'd3, 5'd4, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h555, 3'd4, 5'd5, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'hf0f, 3'd6, 5'd5, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h0ff, 3'd7, 5'd5, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h005, 3'd1, 5'd6, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h01f, 3'd5, 5'd6, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'h407, 3'd5, 5'd6, rv_exec_pkg::OP_I_TYPE), 32'h8000_0f00, 32'h0); // srai
        issue(enc_i(12'h401, 3'd5, 5'd6, rv_exec_pkg::OP_I_TYPE), $random(seed), 32'h0);
        issue(enc_i(12'hffc, 3'd2, 5'd7, rv_exec_pkg::OP_I_TYPE_L), 32'h0000_2000, 32'h0);
        issue(enc_i(12'h064, 3'd0, 5'd8, rv_exec_pkg::OP_I_TYPE_L), $random(seed), 32'h0);
        issue(enc_s(12'hff8, 3'd2), 32'h0000_3000, $random(seed));
        issue(enc_s(12'h00c, 3'd0), $random(seed), $random(seed));
    endtask

    task automatic run_branches();
        issue(enc_b(13'h0010, 3'd0), 32'd5, 32'd5);                 // beq taken
        issue(enc_b(13'h1fe0, 3'd0), 32'd5, 32'd6);
        issue(enc_b(13'h0010, 3'd1), 32'd5, 32'd6);                 // bne taken
        issue(enc_b(13'h1fe0, 3'd1), 32'd5, 32'd5);
        issue(enc_b(13'h0010, 3'd4), 32'hffff_ffff, 32'd1);         // blt taken
        issue(enc_b(13'h1fe0, 3'd4), 32'd1, 32'hffff_ffff);
        issue(enc_b(13'h1fe0, 3'd4), 32'h8000_0000, 32'h7fff_ffff); // overflow case
        issue(enc_b(13'h0010, 3'd5), 32'd1, 32'hffff_ffff);         // bge taken
        issue(enc_b(13'h1fe0, 3'd5), 32'hffff_ffff, 32'd1);
        issue(enc_b(13'h0010, 3'd5), 32'h7fff_ffff, 32'h8000_0000);
        issue(enc_b(13'h1fe0, 3'd6), 32'd1, 32'hffff_ffff);         // bltu taken
        issue(enc_b(13'h0010, 3'd6), 32'hffff_ffff, 32'd1);
        issue(enc_b(13'h0010, 3'd7), 32'hffff_ffff, 32'd1);         // bgeu taken
        issue(enc_b(13'h1fe0, 3'd7), 32'd1, 32'hffff_ffff);
    endtask

    task automatic run_jumps_upper();
        issue(enc_j(21'h000800, 5'd1), 32'h0, 32'h0);
        issue(enc_j(21'h1fff00, 5'd0), 32'h0, 32'h0);  // backward, link to x0
        issue(enc_i(12'h002, 3'd0, 5'd5, rv_exec_pkg::OP_JALR), 32'h0000_1001, 32'h0);
        issue(enc_i(12'hff0, 3'd0, 5'd5, rv_exec_pkg::OP_JALR), 32'h0000_2001, 32'h0);
        issue(enc_u(20'hfffff, 5'd6, rv_exec_pkg::OP_LUI), 32'h0, 32'h0);
        issue(enc_u(20'h12345, 5'd7, rv_exec_pkg::OP_AUIPC), 32'h0, 32'h0);
    endtask

    task automatic run_backpressure();
        logic [31:0] r;
        logic        f7b5;
        stall_mode <= 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            f7b5 = (r[2:0] == 3'd0 || r[2:0] == 3'd5) ? r[3] : 1'b0;
            issue(enc_r(r[2:0], f7b5, r[8:4]), $random(seed), $random(seed));
        end
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        stall_mode <= 1'b0;
    endtask

    task automatic run_illegal();
        issue(32'h0000_0f7f, 32'h11, 32'h22);          // unknown opcode, rd 30
        issue(enc_b(13'h0010, 3'd2), 32'd1, 32'd1);    // no such branch
        issue(enc_b(13'h0010, 3'd3), 32'd1, 32'd2);
        issue(32'h0000_0000, 32'h55, 32'h66);
    endtask

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        cur_pc     = 32'h0000_1000;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state();
        run_r_type();
        run_i_type_mem();
        run_branches();
        run_jumps_upper();
        run_backpressure();
        run_illegal();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        $display("done: %0d responses, %0d value errors, %0d other errors",
                 delivered, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/rv_exec_pkg.sv
logic/rv_ctrl_dec.sv
logic/instr_decode.sv
logic/alu.sv
logic/pipe_stage.sv
logic/exec_result.sv
logic/rv_exec_unit.sv
verification/rv_exec_tb.sv
